//--- cpu_core.f
logic/cpu_pkg.sv
logic/instr_decode.sv
logic/pipe_reg.sv
logic/reg_file.sv
logic/alu.sv
logic/pipe_ctrl.sv
logic/cpu_core.sv
dv/cpu_core_tb.sv

//--- dv/cpu_core_tb.sv
`timescale 1ns/1ps

module cpu_core_tb import cpu_pkg::*; ();

	// about twice the cycles that all tests together take
	localparam int CYCLE_LIMIT = 400;

	typedef struct packed {
		logic is_exc;
		logic [3:0] rd;
		logic [31:0] data;
		exc_cause_t cause;
		logic [31:0] pc;
	} event_t;

	logic clk;
	logic rst_n;
	logic [31:0] instr;
	logic [31:0] pc_plus_4;
	logic instr_fetched;
	logic retire_valid;
	retire_t retire;
	logic exc_valid;
	exc_t exc;

	logic [31:0] model_regs [16];
	event_t exp_q [$];
	logic squash_next;
	logic [31:0] pc_cnt;
	logic [31:0] rng = 32'hca31_4164;
	int errors = 0;
	int missing = 0;
	int checks = 0;
	int cycles = 0;

	cpu_core i_cpu_core (
		.clk(clk),
		.rst_n(rst_n),
		.instr(instr),
		.pc_plus_4(pc_plus_4),
		.instr_fetched(instr_fetched),
		.retire_valid(retire_valid),
		.retire(retire),
		.exc_valid(exc_valid),
		.exc(exc)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run went past %0d cycles", CYCLE_LIMIT);
			$display("Checks failed");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic logic [31:0] enc_rr(input logic [3:0] op, input logic [3:0] rd,
		input logic [3:0] ra, input logic [3:0] rb);
		return {2'b00, 1'b0, op, 13'h0, ra, rb, rd};
	endfunction

	function automatic logic [31:0] enc_ri(input logic [3:0] op, input logic [3:0] rd,
		input logic [3:0] ra, input logic [12:0] imm);
		return {2'b00, 1'b1, op, imm, ra, 4'h0, rd};
	endfunction

	// ra overlays the low bits of imm16
	function automatic logic [31:0] enc_i16(input logic [3:0] op, input logic [3:0] rd,
		input logic [3:0] ra, input logic [15:0] imm);
		logic [31:0] w;
		w = {2'b00, 1'b0, op, imm, 5'h0, rd};
		w[11:8] = ra;
		return w;
	endfunction

	function automatic exc_cause_t model_cause(input logic [31:0] w);
		if (w[31:30] == 2'b00 && w[28:25] <= 4'd10)
			return EXC_NONE;
		if (w[31:30] == 2'b11 && w[29:25] == 5'd0)
			return EXC_SWI;
		if (w[31:30] == 2'b11 && w[29:25] == 5'd1)
			return EXC_BKPT;
		return EXC_ILLEGAL;
	endfunction

	function automatic logic [31:0] model_alu(input logic [31:0] w, input logic [31:0] a,
		input logic [31:0] b);
		logic [31:0] op2;
		logic [4:0] sh;
		op2 = w[29] ? {{19{w[24]}}, w[24:12]} : b;
		sh = op2[4:0];
		case (w[28:25])
		4'd0: return a + op2;
		4'd1: return a - op2;
		4'd2: return a & op2;
		4'd3: return a | op2;
		4'd4: return a ^ op2;
		4'd5: return a << sh;
		4'd6: return a >> sh;
		4'd7: return $unsigned($signed(a) >>> sh);
		4'd9: return {w[24:9], 16'h0};
		4'd10: return a | {16'h0, w[24:9]};
		default: return op2;
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic match_event(input logic is_exc, input logic [31:0] f1,
		input logic [31:0] f2);
		event_t ev;
		if (exp_q.size() == 0) begin
			errors++;
			$display("an output event appeared while none was expected");
		end else begin
			ev = exp_q.pop_front();
			check("event kind", 32'(is_exc), 32'(ev.is_exc));
			if (!is_exc) begin
				check("retire.rd", f1, 32'(ev.rd));
				check("retire.data", f2, ev.data);
			end else begin
				check("exc.cause", f1, 32'(ev.cause));
				check("exc.pc_plus_4", f2, ev.pc);
			end
		end
	endtask

	// outputs settle after the rising edge
	always @(negedge clk) begin
		if (rst_n && retire_valid)
			match_event(1'b0, 32'(retire.rd), retire.data);
		if (rst_n && exc_valid)
			match_event(1'b1, 32'(exc.cause), exc.pc_plus_4);
	end

	task automatic issue(input logic [31:0] w);
		event_t ev;
		@(posedge clk);
		instr <= w;
		pc_plus_4 <= pc_cnt + 32'd4;
		instr_fetched <= 1'b1;
		pc_cnt = pc_cnt + 32'd4;
		if (squash_next) begin
			squash_next = 1'b0;
		end else begin
			ev = '0;
			ev.cause = model_cause(w);
			if (ev.cause != EXC_NONE) begin
				ev.is_exc = 1'b1;
				ev.pc = pc_cnt;
				squash_next = 1'b1;
			end else begin
				ev.rd = w[3:0];
				ev.data = model_alu(w, model_regs[w[11:8]], model_regs[w[7:4]]);
				model_regs[w[3:0]] = ev.data;
			end
			exp_q.push_back(ev);
		end
	endtask

	task automatic bubble();
		@(posedge clk);
		instr_fetched <= 1'b0;
		squash_next = 1'b0;
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < 8) begin
			bubble();
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("%0d expected events never appeared", exp_q.size());
			missing += exp_q.size();
			exp_q.delete();
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		instr_fetched <= 1'b0;
		exp_q.delete();
		squash_next = 1'b0;
		for (int k = 0; k < 16; k++)
			model_regs[k] = '0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic load_test();
		logic [31:0] r;
		for (int k = 0; k < 16; k++) begin
			r = next_rand();
			issue(enc_i16(4'd9, 4'(k), 4'h0, r[31:16]));
			issue(enc_i16(4'd10, 4'(k), 4'(k), r[15:0]));
		end
		drain();
	endtask

	// shifts read r15, which holds a negative value
	task automatic alu_test();
		logic [31:0] r;
		logic [3:0] ra;
		issue(enc_i16(4'd9, 4'd15, 4'd0, 16'hf00d));
		for (int op = 0; op < 11; op++) begin
			r = next_rand();
			ra = (op >= 5 && op <= 7) ? 4'd15 : r[3:0];
			issue(enc_rr(4'(op), r[7:4] % 4'd14, ra, r[27:24]));
			issue(enc_ri(4'(op), r[11:8] % 4'd14, ra, r[24:12]));
		end
		drain();
	endtask

	// immediate forms depend through ra and register forms through rb
	task automatic dependence_test();
		logic [31:0] r;
		logic [3:0] prev;
		logic [3:0] rd;
		for (int gap = 0; gap < 3; gap++) begin
			r = next_rand();
			prev = r[3:0];
			for (int i = 0; i < 6; i++) begin
				r = next_rand();
				rd = r[7:4];
				if (i[0])
					issue(enc_ri(4'(i % 5), rd, prev, r[20:8]));
				else
					issue(enc_rr(4'(i % 5), rd, r[11:8], prev));
				repeat (gap) bubble();
				prev = rd;
			end
			drain();
		end
	endtask

	task automatic exception_test();
		logic [31:0] words [5];
		words[0] = {2'b00, 5'd12, 25'h0};
		words[1] = {2'b01, 5'd0, 25'h0};
		words[2] = {2'b11, 5'd0, 25'h0};
		words[3] = {2'b11, 5'd1, 25'h0};
		words[4] = {2'b11, 5'd9, 25'h0};
		for (int k = 0; k < 5; k++) begin
			issue(words[k]);
			issue(enc_ri(4'd0, 4'd3, 4'd3, 13'h5));
			issue(enc_ri(4'd0, 4'd4, 4'd3, 13'h1));
			drain();
		end
	endtask

	task automatic bubble_reset_test();
		logic [31:0] r;
		r = next_rand();
		issue(enc_ri(4'd0, 4'd1, 4'd2, r[12:0]));
		repeat (3) bubble();
		issue(enc_rr(4'd3, 4'd5, 4'd1, 4'd2));
		bubble();
		drain();
		issue(enc_ri(4'd0, 4'd6, 4'd6, r[25:13]));
		issue(enc_rr(4'd1, 4'd7, 4'd6, 4'd5));
		apply_reset();
		repeat (4) bubble();
		// each register is read before anything writes it again
		for (int k = 0; k < 16; k++)
			issue(enc_rr(4'd8, 4'(k), 4'h0, 4'(k)));
		drain();
	endtask

	initial begin
		rst_n <= 1'b0;
		instr <= '0;
		pc_plus_4 <= '0;
		instr_fetched <= 1'b0;
		pc_cnt = 32'h1000;
		apply_reset();
		load_test();
		alu_test();
		dependence_test();
		exception_test();
		bubble_reset_test();
		repeat (2) bubble();
		$display("errors: %0d mismatches, %0d missing events, %0d checks",
			errors, missing, checks);
		if (errors == 0 && missing == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- logic/alu.sv
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
	input decoded_t dec,
	input logic [31:0] ra_val,
	input logic [31:0] rb_val,
	output logic [31:0] result
);

	logic [31:0] op2;
	logic [4:0] shamt;

	assign op2 = dec.op2_imm ? dec.imm32 : rb_val;
	assign shamt = op2[4:0];

	always_comb begin
		case (dec.alu_opc)
		ALU_ADD: result = ra_val + op2;
		ALU_SUB: result = ra_val - op2;
		ALU_AND: result = ra_val & op2;
		ALU_OR: result = ra_val | op2;
		ALU_XOR: result = ra_val ^ op2;
		ALU_LSL: result = ra_val << shamt;
		ALU_LSR: result = ra_val >> shamt;
		ALU_ASR: result = $unsigned($signed(ra_val) >>> shamt);
		ALU_MOV: result = op2;
		// imm32 holds the zero-extended imm16 here
		ALU_MOVHI: result = {op2[15:0], 16'b0};
		ALU_ORLO: result = ra_val | op2;
		default: result = '0;
		endcase
	end

endmodule

//--- logic/cpu_core.sv
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic [31:0] instr,
	input logic [31:0] pc_plus_4,
	input logic instr_fetched,
	output logic retire_valid,
	output retire_t retire,
	output logic exc_valid,
	output exc_t exc
);

	decoded_t id_dec;
	decoded_t ex_dec;
	logic ex_valid;
	logic flush;
	logic [31:0] rf_ra;
	logic [31:0] rf_rb;
	logic [31:0] fwd_ra;
	logic [31:0] fwd_rb;
	logic [31:0] alu_result;
	logic wb_in_valid;
	retire_t wb_in;

	instr_decode i_instr_decode (
		.instr(instr),
		.pc_plus_4(pc_plus_4),
		.dec(id_dec)
	);

	pipe_reg #(.payload_t(decoded_t)) de_reg (
		.clk(clk),
		.rst_n(rst_n),
		.flush(flush),
		.in_valid(instr_fetched),
		.in_data(id_dec),
		.out_valid(ex_valid),
		.out_data(ex_dec)
	);

	// write port is fed straight from the retire stage
	reg_file i_reg_file (
		.clk(clk),
		.rst_n(rst_n),
		.ra_sel(ex_dec.ra_sel),
		.rb_sel(ex_dec.rb_sel),
		.ra_data(rf_ra),
		.rb_data(rf_rb),
		.wr_en(retire_valid),
		.wr(retire)
	);

	pipe_ctrl i_pipe_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.ex_valid(ex_valid),
		.ex_dec(ex_dec),
		.rf_ra(rf_ra),
		.rf_rb(rf_rb),
		.wb_valid(retire_valid),
		.wb(retire),
		.fwd_ra(fwd_ra),
		.fwd_rb(fwd_rb),
		.wb_in_valid(wb_in_valid),
		.flush(flush),
		.exc_valid(exc_valid),
		.exc(exc)
	);

	alu i_alu (
		.dec(ex_dec),
		.ra_val(fwd_ra),
		.rb_val(fwd_rb),
		.result(alu_result)
	);

	assign wb_in.rd = ex_dec.rd_sel;
	assign wb_in.data = alu_result;

	pipe_reg #(.payload_t(retire_t)) wb_reg (
		.clk(clk),
		.rst_n(rst_n),
		.flush(1'b0),
		.in_valid(wb_in_valid),
		.in_data(wb_in),
		.out_valid(retire_valid),
		.out_data(retire)
	);

endmodule

//--- logic/cpu_pkg.sv
package cpu_pkg;

	// instruction word layout
	localparam int CLASS_HI = 31;
	localparam int CLASS_LO = 30;
	localparam int OPC_HI = 29;
	localparam int OPC_LO = 25;
	localparam int OPC_IMM_BIT = 4;
	localparam int RD_LO = 0;
	localparam int RB_LO = 4;
	localparam int RA_LO = 8;
	localparam int IMM13_HI = 24;
	localparam int IMM13_LO = 12;
	localparam int IMM16_HI = 24;
	localparam int IMM16_LO = 9;

	localparam int REG_SEL_W = 4;
	localparam int NUM_REGS = 16;

	localparam logic [1:0] CLASS_ALU = 2'b00;
	localparam logic [1:0] CLASS_MISC = 2'b11;

	localparam logic [4:0] OPC_SWI = 5'd0;
	localparam logic [4:0] OPC_BKPT = 5'd1;

	// encoding matches the low four opcode bits of class 00
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_LSL,
		ALU_LSR,
		ALU_ASR,
		ALU_MOV,
		ALU_MOVHI,
		ALU_ORLO
	} alu_op_t;

	typedef enum logic [1:0] {
		EXC_NONE,
		EXC_ILLEGAL,
		EXC_SWI,
		EXC_BKPT
	} exc_cause_t;

	typedef struct packed {
		logic [REG_SEL_W-1:0] ra_sel;
		logic [REG_SEL_W-1:0] rb_sel;
		logic [REG_SEL_W-1:0] rd_sel;
		logic update_rd;
		alu_op_t alu_opc;
		logic op2_imm;
		logic [31:0] imm32;
		exc_cause_t cause;
		logic [31:0] pc_plus_4;
	} decoded_t;

	typedef struct packed {
		logic [REG_SEL_W-1:0] rd;
		logic [31:0] data;
	} retire_t;

	typedef struct packed {
		exc_cause_t cause;
		logic [31:0] pc_plus_4;
	} exc_t;

endpackage

//--- logic/instr_decode.sv
`timescale 1ns/1ps

module instr_decode import cpu_pkg::*; (
	input logic [31:0] instr,
	input logic [31:0] pc_plus_4,
	output decoded_t dec
);

	// per-opcode control word from the lookup below
	typedef struct packed {
		logic writes_rd;
		logic use_imm16;
		exc_cause_t cause;
	} ucode_t;

	logic [1:0] iclass;
	logic [4:0] opc;
	logic [12:0] imm13;
	logic [15:0] imm16;
	ucode_t uc;

	assign iclass = instr[CLASS_HI:CLASS_LO];
	assign opc = instr[OPC_HI:OPC_LO];
	assign imm13 = instr[IMM13_HI:IMM13_LO];
	assign imm16 = instr[IMM16_HI:IMM16_LO];

	always_comb begin
		uc = '{writes_rd: 1'b0, use_imm16: 1'b0, cause: EXC_ILLEGAL};
		case (iclass)
		CLASS_ALU: begin
			case (alu_op_t'(opc[3:0]))
			ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
			ALU_LSL, ALU_LSR, ALU_ASR, ALU_MOV: begin
				uc = '{writes_rd: 1'b1, use_imm16: 1'b0, cause: EXC_NONE};
			end
			// the 16-bit immediate forms ignore the imm select bit
			ALU_MOVHI, ALU_ORLO: begin
				uc = '{writes_rd: 1'b1, use_imm16: 1'b1, cause: EXC_NONE};
			end
			default: begin
			end
			endcase
		end
		CLASS_MISC: begin
			case (opc)
			OPC_SWI: uc.cause = EXC_SWI;
			OPC_BKPT: uc.cause = EXC_BKPT;
			default: uc.cause = EXC_ILLEGAL;
			endcase
		end
		default: begin
		end
		endcase
	end

	always_comb begin
		dec.ra_sel = instr[RA_LO +: REG_SEL_W];
		dec.rb_sel = instr[RB_LO +: REG_SEL_W];
		dec.rd_sel = instr[RD_LO +: REG_SEL_W];
		dec.update_rd = uc.writes_rd;
		dec.alu_opc = uc.writes_rd ? alu_op_t'(opc[3:0]) : ALU_ADD;
		dec.op2_imm = opc[OPC_IMM_BIT] | uc.use_imm16;
		if (uc.use_imm16)
			dec.imm32 = {16'b0, imm16};
		else
			dec.imm32 = {{19{imm13[12]}}, imm13};
		dec.cause = uc.cause;
		dec.pc_plus_4 = pc_plus_4;
	end

endmodule

//--- logic/pipe_ctrl.sv
`timescale 1ns/1ps

module pipe_ctrl import cpu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic ex_valid,
	input decoded_t ex_dec,
	input logic [31:0] rf_ra,
	input logic [31:0] rf_rb,
	input logic wb_valid,
	input retire_t wb,
	output logic [31:0] fwd_ra,
	output logic [31:0] fwd_rb,
	output logic wb_in_valid,
	output logic flush,
	output logic exc_valid,
	output exc_t exc
);

	logic raise;

	// retire stage only holds instructions that write rd
	assign fwd_ra = (wb_valid && wb.rd == ex_dec.ra_sel) ? wb.data : rf_ra;
	assign fwd_rb = (wb_valid && wb.rd == ex_dec.rb_sel) ? wb.data : rf_rb;

	// squashed instructions never reach execute with valid set
	assign raise = ex_valid && ex_dec.cause != EXC_NONE;

	// drop the younger instruction entering execute on the same edge
	assign flush = raise;

	assign wb_in_valid = ex_valid && !raise && ex_dec.update_rd;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			exc_valid <= 1'b0;
		else
			exc_valid <= raise;
	end

	always_ff @(posedge clk) begin
		if (raise) begin
			exc.cause <= ex_dec.cause;
			exc.pc_plus_4 <= ex_dec.pc_plus_4;
		end
	end

endmodule

//--- logic/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = logic [31:0]
) (
	input logic clk,
	input logic rst_n,
	input logic flush,
	input logic in_valid,
	input payload_t in_data,
	output logic out_valid,
	output payload_t out_data
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (flush)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	// payload only moves with a valid stage
	always_ff @(posedge clk) begin
		if (in_valid)
			out_data <= in_data;
	end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic [REG_SEL_W-1:0] ra_sel,
	input logic [REG_SEL_W-1:0] rb_sel,
	output logic [31:0] ra_data,
	output logic [31:0] rb_data,
	input logic wr_en,
	input retire_t wr
);

	logic [31:0] regs [NUM_REGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			regs <= '{default: '0};
		else if (wr_en)
			regs[wr.rd] <= wr.data;
	end

	// reads see the old value on a same-cycle write, forwarding covers it
	assign ra_data = regs[ra_sel];
	assign rb_data = regs[rb_sel];

endmodule

//--- run_sim.sh
#!/bin/sh
# compile and run the cpu_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -f cpu_core.f --top-module cpu_core_tb -Mdir obj_dir -o cpu_core_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/cpu_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Checks failed" "$LOG"; then
	exit 1
fi

exit 0
